// ==== flist.f ====
+incdir+.
rv_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_bus_arbiter.sv
rv_core.sv
rv_system.sv
tb_memory.sv
tb_rv_system.sv

// ==== rv_alu.sv ====
// Combinational ALU with comparator and branch decision
`timescale 1ns/1ps

module rv_alu (
	input  rv_pkg::word_t   alu_a,
	input  rv_pkg::word_t   alu_b,
	input  rv_pkg::alu_op_e alu_op,
	input  rv_pkg::cmp_op_e cmp_op,
	input  logic            branch_invert,
	output rv_pkg::word_t   alu_out,
	output logic            branch_taken
);

	logic [4:0] shamt;
	logic       cmp_result;

	assign shamt = alu_b[4:0]; // Only the low five bits shift

	always_comb begin
		case (alu_op)
			rv_pkg::ADD: alu_out = alu_a + alu_b;
			rv_pkg::SUB: alu_out = alu_a - alu_b;
			rv_pkg::SLL: alu_out = alu_a << shamt;
			rv_pkg::SRL: alu_out = alu_a >> shamt;
			rv_pkg::SRA: alu_out = $signed(alu_a) >>> shamt;
			rv_pkg::XOR: alu_out = alu_a ^ alu_b;
			rv_pkg::OR:  alu_out = alu_a | alu_b;
			rv_pkg::AND: alu_out = alu_a & alu_b;
			default:     alu_out = alu_a + alu_b;
		endcase
	end

	// Comparator
	always_comb begin
		case (cmp_op)
			rv_pkg::EQ:  cmp_result = (alu_a == alu_b);
			rv_pkg::LT:  cmp_result = ($signed(alu_a) < $signed(alu_b));
			rv_pkg::LTU: cmp_result = (alu_a < alu_b);
			default:     cmp_result = 1'b0;
		endcase
	end

	// BNE, BGE and BGEU come from the inverted result
	assign branch_taken = cmp_result ^ branch_invert;

endmodule

// ==== rv_bus_arbiter.sv ====
// Fixed-priority arbiter sharing one memory bus between the fetch and data ports
`timescale 1ns/1ps

module rv_bus_arbiter (
	input  logic          clock,
	input  logic          reset,
	input  rv_pkg::word_t iaddr,
	input  logic          ivalid,
	output logic          iready,
	output rv_pkg::word_t idata,
	input  rv_pkg::word_t daddr,
	input  rv_pkg::word_t dwdata,
	input  rv_pkg::strb_t dstrb,
	input  logic          dwrite,
	input  logic          dvalid,
	output logic          dready,
	output rv_pkg::word_t drdata,
	output rv_pkg::word_t mem_addr,
	output rv_pkg::word_t mem_wdata,
	output rv_pkg::strb_t mem_strb,
	output logic          mem_write,
	output logic          mem_valid,
	input  logic          mem_ready,
	input  rv_pkg::word_t mem_rdata
);

	typedef enum logic [1:0] {
		GNT_IDLE,
		GNT_FETCH,
		GNT_DATA
	} grant_e;

	grant_e grant; // Held while a transfer waits
	grant_e owner;

	// Data wins over fetch when the bus is free
	always_comb begin
		if (grant != GNT_IDLE) begin
			owner = grant;
		end else if (dvalid) begin
			owner = GNT_DATA;
		end else if (ivalid) begin
			owner = GNT_FETCH;
		end else begin
			owner = GNT_IDLE;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			grant <= GNT_IDLE;
		end else if (grant == GNT_IDLE) begin
			if (owner != GNT_IDLE && !mem_ready) begin
				grant <= owner;
			end
		end else if (mem_ready) begin
			grant <= GNT_IDLE; // Completing cycle
		end
	end

	assign mem_valid = (owner == GNT_DATA) ? dvalid : ((owner == GNT_FETCH) && ivalid);
	assign mem_addr  = (owner == GNT_DATA) ? daddr : iaddr;
	assign mem_wdata = (owner == GNT_DATA) ? dwdata : '0;
	assign mem_strb  = (owner == GNT_DATA) ? dstrb : 4'b1111;
	assign mem_write = (owner == GNT_DATA) && dwrite; // Fetches always read

	assign iready = (owner == GNT_FETCH) && mem_ready;
	assign dready = (owner == GNT_DATA) && mem_ready;
	assign idata  = (owner == GNT_FETCH) ? mem_rdata : '0;
	assign drdata = (owner == GNT_DATA) ? mem_rdata : '0;

endmodule

// ==== rv_core.sv ====
// RV32I core control: FSM, PC and instruction registers, decode, immediates, load/store lanes
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
	input  logic              clock,
	input  logic              reset,
	output rv_pkg::word_t     iaddr,
	output logic              ivalid,
	input  logic              iready,
	input  rv_pkg::word_t     idata,
	output rv_pkg::word_t     daddr,
	output rv_pkg::word_t     dwdata,
	output rv_pkg::strb_t     dstrb,
	output logic              dwrite,
	output logic              dvalid,
	input  logic              dready,
	input  rv_pkg::word_t     drdata,
	output rv_pkg::reg_addr_t ra_raddr,
	output rv_pkg::reg_addr_t rb_raddr,
	input  rv_pkg::word_t     ra_rdata,
	input  rv_pkg::word_t     rb_rdata,
	output rv_pkg::reg_addr_t rd_waddr,
	output rv_pkg::word_t     rd_wdata,
	output logic              rd_wen,
	output rv_pkg::word_t     alu_a,
	output rv_pkg::word_t     alu_b,
	output rv_pkg::alu_op_e   alu_op,
	output rv_pkg::cmp_op_e   cmp_op,
	output logic              branch_invert,
	input  rv_pkg::word_t     alu_out,
	input  logic              branch_taken
);

	rv_pkg::core_state_e state;
	rv_pkg::word_t       pc;
	rv_pkg::word_t       instr;
	rv_pkg::word_t       pc_plus4;
	rv_pkg::word_t       pc_next;
	logic                fetch_req;   // Instruction request pending
	logic                take_branch; // Compare result captured in DECODE

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       op_load, op_store, op_branch, op_imm, op_op;
	logic       op_jal, op_jalr, op_lui, op_auipc;
	logic       op_slt;
	logic       writes_rd;

	rv_pkg::word_t imm_i, imm_s, imm_b, imm_u, imm_j;
	rv_pkg::word_t byte_lane;
	logic [15:0]   half_lane;
	rv_pkg::word_t load_data;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	assign op_load   = (opcode == `RV_OPC_LOAD);
	assign op_store  = (opcode == `RV_OPC_STORE);
	assign op_branch = (opcode == `RV_OPC_BRANCH);
	assign op_imm    = (opcode == `RV_OPC_OP_IMM);
	assign op_op     = (opcode == `RV_OPC_OP);
	assign op_jal    = (opcode == `RV_OPC_JAL);
	assign op_jalr   = (opcode == `RV_OPC_JALR);
	assign op_lui    = (opcode == `RV_OPC_LUI);
	assign op_auipc  = (opcode == `RV_OPC_AUIPC);
	assign op_slt    = (op_op || op_imm) && (funct3[2:1] == 2'b01); // SLT(I), SLT(I)U
	assign writes_rd = op_lui || op_auipc || op_jal || op_jalr || op_op || op_imm;

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'h000};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Register fields sit in fixed positions
	assign ra_raddr = instr[19:15];
	assign rb_raddr = instr[24:20];
	assign rd_waddr = instr[11:7];

	assign pc_plus4 = pc + 32'd4;
	assign iaddr    = pc;
	assign ivalid   = fetch_req;
	assign daddr    = {alu_out[31:2], 2'b00}; // Word address, lanes via strobe
	assign dvalid   = (state == rv_pkg::MEM_READ) || (state == rv_pkg::MEM_WRITE);
	assign dwrite   = (state == rv_pkg::MEM_WRITE);

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= rv_pkg::FETCH;
			pc          <= `RV_RESET_VECTOR;
			fetch_req   <= 1'b0;
			take_branch <= 1'b0;
		end else begin
			case (state)
				rv_pkg::FETCH: begin
					if (!fetch_req) begin
						fetch_req <= 1'b1; // Only after reset
					end else if (iready) begin
						fetch_req <= 1'b0;
						state     <= rv_pkg::DECODE;
					end
				end
				rv_pkg::DECODE: begin
					take_branch <= branch_taken; // rs1 vs rs2 on the comparator
					state       <= rv_pkg::EXECUTE;
				end
				rv_pkg::EXECUTE: begin
					if (op_load) begin
						state <= rv_pkg::MEM_READ;
					end else if (op_store) begin
						state <= rv_pkg::MEM_WRITE;
					end else begin
						pc        <= pc_next;
						fetch_req <= 1'b1;
						state     <= rv_pkg::FETCH;
					end
				end
				rv_pkg::MEM_READ, rv_pkg::MEM_WRITE: begin
					if (dready) begin
						pc        <= pc_next;
						fetch_req <= 1'b1;
						state     <= rv_pkg::FETCH;
					end
				end
				default: state <= rv_pkg::FETCH;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr <= idata;
		end
	end

	// Comparator setup
	always_comb begin
		if (op_branch) begin
			case (funct3[2:1])
				2'b00:   cmp_op = rv_pkg::EQ;  // BEQ, BNE
				2'b10:   cmp_op = rv_pkg::LT;  // BLT, BGE
				default: cmp_op = rv_pkg::LTU; // BLTU, BGEU
			endcase
			branch_invert = funct3[0];
		end else begin
			cmp_op        = funct3[0] ? rv_pkg::LTU : rv_pkg::LT;
			branch_invert = 1'b0;
		end
	end

	// Operand select, register operands by default
	always_comb begin
		alu_a  = ra_rdata;
		alu_b  = rb_rdata;
		alu_op = rv_pkg::ADD;
		if (op_lui) begin
			alu_a = '0;
			alu_b = imm_u;
		end else if (op_auipc) begin
			alu_a = pc;
			alu_b = imm_u;
		end else if (op_jal) begin
			alu_a = pc;
			alu_b = imm_j;
		end else if (op_jalr || op_load || op_imm) begin
			alu_b = imm_i;
		end else if (op_store) begin
			alu_b = imm_s;
		end else if (op_branch && state != rv_pkg::DECODE) begin
			alu_a = pc; // Target once the compare is latched
			alu_b = imm_b;
		end

		if (op_op || op_imm) begin
			case (funct3)
				3'b000:  alu_op = (op_op && instr[30]) ? rv_pkg::SUB : rv_pkg::ADD;
				3'b001:  alu_op = rv_pkg::SLL;
				3'b100:  alu_op = rv_pkg::XOR;
				3'b101:  alu_op = instr[30] ? rv_pkg::SRA : rv_pkg::SRL;
				3'b110:  alu_op = rv_pkg::OR;
				3'b111:  alu_op = rv_pkg::AND;
				default: alu_op = rv_pkg::ADD; // SLT forms use the comparator
			endcase
		end
	end

	// Store lanes
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				dstrb  = 4'b0001 << alu_out[1:0];
				dwdata = {4{rb_rdata[7:0]}};
			end
			2'b01: begin
				dstrb  = alu_out[1] ? 4'b1100 : 4'b0011;
				dwdata = {2{rb_rdata[15:0]}};
			end
			default: begin
				dstrb  = 4'b1111;
				dwdata = rb_rdata;
			end
		endcase
	end

	// Load lanes, funct3[2] selects zero extension
	assign byte_lane = drdata >> {alu_out[1:0], 3'b000};
	assign half_lane = alu_out[1] ? drdata[31:16] : drdata[15:0];

	always_comb begin
		case (funct3[1:0])
			2'b00:   load_data = {{24{byte_lane[7] & ~funct3[2]}}, byte_lane[7:0]};
			2'b01:   load_data = {{16{half_lane[15] & ~funct3[2]}}, half_lane};
			default: load_data = drdata;
		endcase
	end

	always_comb begin
		if (op_jal || op_jalr) begin
			rd_wdata = pc_plus4; // Link address
		end else if (op_load) begin
			rd_wdata = load_data;
		end else if (op_slt) begin
			rd_wdata = {31'b0, branch_taken};
		end else begin
			rd_wdata = alu_out;
		end
	end

	// x0 is never written
	assign rd_wen = (rd_waddr != 5'd0) &&
		((state == rv_pkg::EXECUTE && writes_rd) || (state == rv_pkg::MEM_READ && dready));

	always_comb begin
		if (op_jal || (op_branch && take_branch)) begin
			pc_next = alu_out;
		end else if (op_jalr) begin
			pc_next = {alu_out[31:1], 1'b0};
		end else begin
			pc_next = pc_plus4;
		end
	end

endmodule

// ==== rv_defines.svh ====
// Reset vector, RV32I opcode field values and register count
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// First fetch address
`define RV_RESET_VECTOR 32'h0000_0000

// Major opcodes, instr[6:0]
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111

`define RV_NUM_REGS 32

`endif

// ==== rv_pkg.sv ====
// Width typedefs and the core state, ALU operation and compare operation enums
package rv_pkg;

	typedef logic [31:0] word_t;     // Data or address word
	typedef logic [4:0]  reg_addr_t; // Register index
	typedef logic [3:0]  strb_t;     // Byte lane strobes

	// Multi-cycle core sequence
	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEM_READ,
		MEM_WRITE
	} core_state_e;

	typedef enum logic [2:0] {
		ADD,
		SUB,
		SLL,
		SRL,
		SRA,
		XOR,
		OR,
		AND
	} alu_op_e;

	// Comparator, signed and unsigned less-than
	typedef enum logic [1:0] {
		EQ,
		LT,
		LTU
	} cmp_op_e;

endpackage

// ==== rv_regfile.sv ====
// 32x32 register file, two asynchronous read ports and one synchronous write port
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
	input  logic              clock,
	input  logic              reset,
	input  rv_pkg::reg_addr_t ra_raddr,
	input  rv_pkg::reg_addr_t rb_raddr,
	output rv_pkg::word_t     ra_rdata,
	output rv_pkg::word_t     rb_rdata,
	input  rv_pkg::reg_addr_t rd_waddr,
	input  rv_pkg::word_t     rd_wdata,
	input  logic              rd_wen
);

	rv_pkg::word_t regs [`RV_NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RV_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_wen) begin
			regs[rd_waddr] <= rd_wdata;
		end
	end

	// x0 reads as zero
	assign ra_rdata = (ra_raddr == 5'd0) ? '0 : regs[ra_raddr];
	assign rb_rdata = (rb_raddr == 5'd0) ? '0 : regs[rb_raddr];

endmodule

// ==== rv_system.sv ====
// Top level: core, register file, ALU and bus arbiter on one shared memory bus
`timescale 1ns/1ps

module rv_system (
	input  logic          clock,
	input  logic          reset,
	output rv_pkg::word_t mem_addr,
	output rv_pkg::word_t mem_wdata,
	output rv_pkg::strb_t mem_strb,
	output logic          mem_write,
	output logic          mem_valid,
	input  logic          mem_ready,
	input  rv_pkg::word_t mem_rdata
);

	rv_pkg::word_t     iaddr, idata;
	logic              ivalid, iready;
	rv_pkg::word_t     daddr, dwdata, drdata;
	rv_pkg::strb_t     dstrb;
	logic              dwrite, dvalid, dready;
	rv_pkg::reg_addr_t ra_raddr, rb_raddr, rd_waddr;
	rv_pkg::word_t     ra_rdata, rb_rdata, rd_wdata;
	logic              rd_wen;
	rv_pkg::word_t     alu_a, alu_b, alu_out;
	rv_pkg::alu_op_e   alu_op;
	rv_pkg::cmp_op_e   cmp_op;
	logic              branch_invert, branch_taken;

	rv_core u_core (
		.clock(clock), .reset(reset),
		.iaddr(iaddr), .ivalid(ivalid), .iready(iready), .idata(idata),
		.daddr(daddr), .dwdata(dwdata), .dstrb(dstrb), .dwrite(dwrite),
		.dvalid(dvalid), .dready(dready), .drdata(drdata),
		.ra_raddr(ra_raddr), .rb_raddr(rb_raddr), .ra_rdata(ra_rdata), .rb_rdata(rb_rdata),
		.rd_waddr(rd_waddr), .rd_wdata(rd_wdata), .rd_wen(rd_wen),
		.alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .cmp_op(cmp_op),
		.branch_invert(branch_invert), .alu_out(alu_out), .branch_taken(branch_taken)
	);

	rv_regfile u_regfile (
		.clock(clock), .reset(reset),
		.ra_raddr(ra_raddr), .rb_raddr(rb_raddr), .ra_rdata(ra_rdata), .rb_rdata(rb_rdata),
		.rd_waddr(rd_waddr), .rd_wdata(rd_wdata), .rd_wen(rd_wen)
	);

	rv_alu u_alu (
		.alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .cmp_op(cmp_op),
		.branch_invert(branch_invert), .alu_out(alu_out), .branch_taken(branch_taken)
	);

	rv_bus_arbiter u_arbiter (
		.clock(clock), .reset(reset),
		.iaddr(iaddr), .ivalid(ivalid), .iready(iready), .idata(idata),
		.daddr(daddr), .dwdata(dwdata), .dstrb(dstrb), .dwrite(dwrite),
		.dvalid(dvalid), .dready(dready), .drdata(drdata),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_strb(mem_strb),
		.mem_write(mem_write), .mem_valid(mem_valid),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

endmodule

// ==== tb_memory.sv ====
// Testbench memory model with program image, address fill pattern, byte strobes and wait states
`timescale 1ns/1ps

module tb_memory #(
	parameter int unsigned rand_seed = 32'h0
) (
	input  logic          clock,
	input  logic          reset,
	input  rv_pkg::word_t mem_addr,
	input  rv_pkg::word_t mem_wdata,
	input  rv_pkg::strb_t mem_strb,
	input  logic          mem_write,
	input  logic          mem_valid,
	output logic          mem_ready,
	output rv_pkg::word_t mem_rdata
);

	rv_pkg::word_t mem [1024]; // 4 KB, word index from mem_addr[11:2]
	integer        seed;
	int            wait_left;
	logic          busy;       // Request accepted, answer pending

	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = 32'ha5a5_0000 ^ (i << 2);
		end
		$readmemh("tb_program.hex", mem);
		seed      = rand_seed;
		wait_left = 0;
		busy      = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
	end

	// Answers are driven just after the rising edge
	always @(posedge clock) begin
		#1;
		if (reset) begin
			mem_ready = 1'b0;
			busy      = 1'b0;
		end else begin
			if (mem_ready) begin
				mem_ready = 1'b0; // Transfer completed at this edge
				busy      = 1'b0;
			end
			if (mem_valid && !busy) begin
				busy      = 1'b1;
				wait_left = $random(seed) & 3;
			end
			if (busy) begin
				if (wait_left == 0) begin
					if (mem_write) begin
						for (int b = 0; b < 4; b++) begin
							if (mem_strb[b]) begin
								mem[mem_addr[11:2]][b*8 +: 8] = mem_wdata[b*8 +: 8];
							end
						end
					end
					mem_rdata = mem[mem_addr[11:2]];
					mem_ready = 1'b1;
				end else begin
					wait_left--;
				end
			end
		end
	end

endmodule

// ==== tb_program.hex ====
// One 32-bit word per line from byte address 0x00 upward, then the assembly
// The last word at 0xb8 is the data word read by the load tests
123452B7 // 00 lui   x5, 0x12345
67828293 // 04 addi  x5, x5, 0x678
20502023 // 08 sw    x5, 0x200(x0)
00001317 // 0c auipc x6, 0x1
20602223 // 10 sw    x6, 0x204(x0)
FFD00393 // 14 addi  x7, x0, -3
40728433 // 18 sub   x8, x5, x7
20802423 // 1c sw    x8, 0x208(x0)
0072C4B3 // 20 xor   x9, x5, x7
20902623 // 24 sw    x9, 0x20c(x0)
4044D513 // 28 srai  x10, x9, 4
20A02823 // 2c sw    x10, 0x210(x0)
0074D633 // 30 srl   x12, x9, x7
20C02A23 // 34 sw    x12, 0x214(x0)
0053A6B3 // 38 slt   x13, x7, x5
20D02C23 // 3c sw    x13, 0x218(x0)
0053B733 // 40 sltu  x14, x7, x5
20E02E23 // 44 sw    x14, 0x21c(x0)
225006A3 // 48 sb    x5, 0x22d(x0)
22901923 // 4c sh    x9, 0x232(x0)
0B900783 // 50 lb    x15, 0xb9(x0)
22F02A23 // 54 sw    x15, 0x234(x0)
0B904803 // 58 lbu   x16, 0xb9(x0)
23002C23 // 5c sw    x16, 0x238(x0)
0BA01883 // 60 lh    x17, 0xba(x0)
23102E23 // 64 sw    x17, 0x23c(x0)
0BA05903 // 68 lhu   x18, 0xba(x0)
25202023 // 6c sw    x18, 0x240(x0)
0B802983 // 70 lw    x19, 0xb8(x0)
25302223 // 74 sw    x19, 0x244(x0)
00100A13 // 78 addi  x20, x0, 1
0053D463 // 7c bge   x7, x5, +8   not taken
002A0A13 // 80 addi  x20, x20, 2
0072E463 // 84 bltu  x5, x7, +8   taken
004A0A13 // 88 addi  x20, x20, 4  skipped
00800AEF // 8c jal   x21, +8
010A0A13 // 90 addi  x20, x20, 16 skipped
25502423 // 94 sw    x21, 0x248(x0)
0A500B13 // 98 addi  x22, x0, 0xa5
000B0BE7 // 9c jalr  x23, 0(x22)
020A0A13 // a0 addi  x20, x20, 32 skipped
25702623 // a4 sw    x23, 0x24c(x0)
25402823 // a8 sw    x20, 0x250(x0)
00100C13 // ac addi  x24, x0, 1
11802023 // b0 sw    x24, 0x100(x0)
0000006F // b4 jal   x0, 0
8765C3A9 // b8 data word

// ==== tb_rv_system.sv ====
// Testbench top with clock, reset, DUT, memory model, expected store table and bus checks
`timescale 1ns/1ps

module tb_rv_system;

	localparam rv_pkg::word_t done_addr    = 32'h0000_0100;
	localparam rv_pkg::word_t sig_base     = 32'h0000_0200;
	localparam int            num_sigs     = 18;
	localparam int            done_timeout = 5000; // Cycles after reset
	localparam int unsigned   seed_value   = 32'hb843;

	logic          clock = 1'b0;
	logic          reset;
	rv_pkg::word_t mem_addr, mem_wdata, mem_rdata;
	rv_pkg::strb_t mem_strb;
	logic          mem_write, mem_valid, mem_ready;

	rv_pkg::word_t exp_addr [num_sigs];
	rv_pkg::word_t exp_data [num_sigs];
	rv_pkg::strb_t exp_strb [num_sigs];
	int            exp_count;
	int            sig_count;
	int            errors;
	int            cycles;
	logic          done_seen;
	logic          first_seen;
	logic          pending; // Valid without ready in the previous cycle
	rv_pkg::word_t held_addr, held_wdata;
	rv_pkg::strb_t held_strb;
	logic          held_write;

	rv_system DUT (
		.clock(clock), .reset(reset),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_strb(mem_strb),
		.mem_write(mem_write), .mem_valid(mem_valid),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	tb_memory #(.rand_seed(seed_value)) u_memory (
		.clock(clock), .reset(reset),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_strb(mem_strb),
		.mem_write(mem_write), .mem_valid(mem_valid),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata)
	);

	always #4 clock = ~clock; // 8 ns period

	task automatic value_mismatch(input string name, input rv_pkg::word_t expected,
			input rv_pkg::word_t actual);
		$display("[FAIL] %0d ns %s expected %h actual %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_problem(input string text);
		$display("Error at %0d ns: %s", $time, text);
		errors++;
	endtask

	task automatic add_expected(input rv_pkg::word_t offset, input rv_pkg::word_t data,
			input rv_pkg::strb_t strb);
		exp_addr[exp_count] = sig_base + offset;
		exp_data[exp_count] = data;
		exp_strb[exp_count] = strb;
		exp_count++;
	endtask

	// Signature stores in program order
	task automatic load_expected();
		add_expected(32'h00, 32'h1234_5678, 4'b1111); // LUI then ADDI
		add_expected(32'h04, 32'h0000_100c, 4'b1111); // AUIPC at 0x0c
		add_expected(32'h08, 32'h1234_567b, 4'b1111); // x5 minus -3
		add_expected(32'h0c, 32'hedcb_a985, 4'b1111); // XOR
		add_expected(32'h10, 32'hfedc_ba98, 4'b1111); // SRAI by 4
		add_expected(32'h14, 32'h0000_0007, 4'b1111); // SRL by 29 from x7
		add_expected(32'h18, 32'h0000_0001, 4'b1111); // SLT
		add_expected(32'h1c, 32'h0000_0000, 4'b1111); // SLTU
		add_expected(32'h2c, 32'h7878_7878, 4'b0010); // SB to 0x22d
		add_expected(32'h30, 32'ha985_a985, 4'b1100); // SH to 0x232
		add_expected(32'h34, 32'hffff_ffc3, 4'b1111); // LB
		add_expected(32'h38, 32'h0000_00c3, 4'b1111); // LBU
		add_expected(32'h3c, 32'hffff_8765, 4'b1111); // LH
		add_expected(32'h40, 32'h0000_8765, 4'b1111); // LHU
		add_expected(32'h44, 32'h8765_c3a9, 4'b1111); // LW
		add_expected(32'h48, 32'h0000_0090, 4'b1111); // Link of JAL at 0x8c
		add_expected(32'h4c, 32'h0000_00a0, 4'b1111); // Link of JALR at 0x9c
		add_expected(32'h50, 32'h0000_0003, 4'b1111); // Branch marker
	endtask

	task automatic check_store();
		if (mem_addr == done_addr) begin
			assert (mem_wdata == 32'd1) else value_mismatch("mem_wdata", 32'd1, mem_wdata);
			done_seen = 1'b1;
		end else if (sig_count >= num_sigs) begin
			report_problem("a store arrived after the last expected signature store");
		end else begin
			assert (mem_addr == exp_addr[sig_count])
				else value_mismatch("mem_addr", exp_addr[sig_count], mem_addr);
			assert (mem_wdata == exp_data[sig_count])
				else value_mismatch("mem_wdata", exp_data[sig_count], mem_wdata);
			assert (mem_strb == exp_strb[sig_count])
				else value_mismatch("mem_strb", exp_strb[sig_count], mem_strb);
			sig_count++;
		end
	endtask

	// Bus is stable at the falling edge
	always @(negedge clock) begin
		if (reset) begin
			assert (!mem_valid) else report_problem("mem_valid is high while reset is held");
			pending = 1'b0;
		end else begin
			if (mem_valid && !first_seen) begin
				first_seen = 1'b1;
				assert (mem_addr == 32'h0) else value_mismatch("mem_addr", 32'h0, mem_addr);
				assert (!mem_write) else report_problem("first request after reset is a write");
			end
			if (pending) begin
				assert (mem_valid) else report_problem("mem_valid dropped before mem_ready");
				assert (mem_addr == held_addr) else value_mismatch("mem_addr", held_addr, mem_addr);
				assert (mem_write == held_write)
					else value_mismatch("mem_write", held_write, mem_write);
				assert (mem_strb == held_strb) else value_mismatch("mem_strb", held_strb, mem_strb);
				assert (mem_wdata == held_wdata)
					else value_mismatch("mem_wdata", held_wdata, mem_wdata);
			end
			if (mem_valid && mem_ready && mem_write) begin
				check_store();
			end
			pending    = mem_valid && !mem_ready;
			held_addr  = mem_addr;
			held_wdata = mem_wdata;
			held_strb  = mem_strb;
			held_write = mem_write;
		end
	end

	initial begin
		reset      = 1'b1;
		errors     = 0;
		exp_count  = 0;
		sig_count  = 0;
		cycles     = 0;
		done_seen  = 1'b0;
		first_seen = 1'b0;
		pending    = 1'b0;
		load_expected();
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;
		while (!done_seen && cycles < done_timeout) begin
			@(posedge clock);
			cycles++;
		end
		if (!done_seen) begin
			report_problem("the program never reached its end store before the timeout");
		end else if (sig_count != num_sigs) begin
			report_problem($sformatf("only %0d of %0d signature stores were seen",
				sig_count, num_sigs));
		end
		$display("Signature stores checked: %0d, errors: %0d", sig_count, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
